//--- rtl/game_pkg.sv
// ==========================================================
// arena game shared types and constants
// ==========================================================

package game_pkg;

	// screen coordinate, enough for 1024 columns
	typedef logic [9:0] coord_t;

	// 12 bit colour, 4 bits per channel
	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb_t;

	// solid box sprite, x/y is the top-left corner
	typedef struct packed {
		coord_t x;
		coord_t y;
		coord_t size; // side length in pixels
		logic   alive;
	} sprite_t;

	// ==========================================================
	// usb hid usage codes
	// ==========================================================
	localparam logic [7:0] key_up      = 8'h1a; // w
	localparam logic [7:0] key_left    = 8'h04; // a
	localparam logic [7:0] key_down    = 8'h16; // s
	localparam logic [7:0] key_right   = 8'h07; // d
	localparam logic [7:0] key_attack  = 8'h2c; // space
	localparam logic [7:0] key_restart = 8'h28; // enter

	// ==========================================================
	// palette
	// ==========================================================
	localparam rgb_t col_bg     = '{r: 4'h1, g: 4'h3, b: 4'h1}; // dark grass
	localparam rgb_t col_player = '{r: 4'h2, g: 4'hc, b: 4'hf}; // light blue
	localparam rgb_t col_enemy  = '{r: 4'he, g: 4'h2, b: 4'h2}; // red

endpackage

//--- rtl/video_timing.sv
// ==========================================================
// video raster timing
// ==========================================================
`timescale 1ns/1ps

module video_timing #(
	parameter int h_active = 640,
	parameter int h_total  = 800,
	parameter int v_active = 480,
	parameter int v_total  = 525,
	parameter int h_sync   = 96,
	parameter int v_sync   = 2
) (
	input  logic            clk,
	input  logic            rst,
	output game_pkg::coord_t draw_x,
	output game_pkg::coord_t draw_y,
	output logic            blank,
	output logic            hs,
	output logic            vs,
	output logic            frame_tick
);
	import game_pkg::*;

	coord_t h_cnt; // current column
	coord_t v_cnt; // current line

	// sync windows start after a two pixel / two line front porch
	localparam coord_t hs_start = coord_t'(h_active + 2);
	localparam coord_t hs_end   = coord_t'(h_active + 2 + h_sync);
	localparam coord_t vs_start = coord_t'(v_active + 2);
	localparam coord_t vs_end   = coord_t'(v_active + 2 + v_sync);

	// ==========================================================
	// raster counters, one pixel per clk
	// ==========================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_cnt == coord_t'(h_total - 1)) begin
			h_cnt <= '0; // end of line
			if (v_cnt == coord_t'(v_total - 1))
				v_cnt <= '0; // end of frame
			else
				v_cnt <= v_cnt + coord_t'(1);
		end else begin
			h_cnt <= h_cnt + coord_t'(1);
		end
	end

	assign draw_x = h_cnt;
	assign draw_y = v_cnt;

	// outside the active area in either direction
	assign blank = (h_cnt >= coord_t'(h_active)) || (v_cnt >= coord_t'(v_active));

	// active low syncs
	assign hs = !((h_cnt >= hs_start) && (h_cnt < hs_end));
	assign vs = !((v_cnt >= vs_start) && (v_cnt < vs_end));

	// first clk of vertical blank, once per frame
	assign frame_tick = (h_cnt == '0) && (v_cnt == coord_t'(v_active));

endmodule

//--- rtl/player_motion.sv
// ==========================================================
// player sprite movement
// ==========================================================
`timescale 1ns/1ps

module player_motion #(
	parameter int h_active    = 640,
	parameter int v_active    = 480,
	parameter int player_size = 32,
	parameter int player_step = 4
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              frame_tick,
	input  logic              run,
	input  logic              restart,
	input  logic [7:0]        keycode,
	output game_pkg::sprite_t player
);
	import game_pkg::*;

	localparam coord_t x_home = coord_t'((h_active - player_size) / 2); // field centre
	localparam coord_t y_home = coord_t'((v_active - player_size) / 2);
	localparam coord_t x_max  = coord_t'(h_active - player_size); // last legal corner
	localparam coord_t y_max  = coord_t'(v_active - player_size);
	localparam coord_t step   = coord_t'(player_step);

	coord_t pos_x;
	coord_t pos_y;

	always_ff @(posedge clk) begin
		if (rst || restart) begin
			pos_x <= x_home;
			pos_y <= y_home;
		end else if (frame_tick && run) begin
			case (keycode)
				key_up:    pos_y <= (pos_y < step) ? '0 : pos_y - step;
				key_down:  pos_y <= (pos_y > y_max - step) ? y_max : pos_y + step;
				key_left:  pos_x <= (pos_x < step) ? '0 : pos_x - step;
				key_right: pos_x <= (pos_x > x_max - step) ? x_max : pos_x + step;
				default:   ; // attack or no key, hold still
			endcase
		end
	end

	// only drawn while playing
	assign player = '{x: pos_x, y: pos_y, size: coord_t'(player_size), alive: run};

endmodule

//--- rtl/enemy_mover.sv
// ==========================================================
// bouncing enemy
// ==========================================================
`timescale 1ns/1ps

module enemy_mover #(
	parameter int h_active     = 640,
	parameter int v_active     = 480,
	parameter int start_x      = 2,
	parameter int start_y      = 2,
	parameter bit start_dx_neg = 1'b0,
	parameter int enemy_size   = 32,
	parameter int enemy_step   = 2
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              frame_tick,
	input  logic              run,
	input  logic              restart,
	input  logic              kill,
	output game_pkg::sprite_t enemy
);
	import game_pkg::*;

	localparam coord_t x_max = coord_t'(h_active - enemy_size);
	localparam coord_t y_max = coord_t'(v_active - enemy_size);
	localparam coord_t step  = coord_t'(enemy_step);

	coord_t pos_x;
	coord_t pos_y;
	logic   dx_neg; // 1 = moving left
	logic   dy_neg; // 1 = moving up
	logic   alive;

	// ==========================================================
	// position and direction, one step per frame
	// ==========================================================
	always_ff @(posedge clk) begin
		if (rst || restart) begin
			pos_x  <= coord_t'(start_x);
			pos_y  <= coord_t'(start_y);
			dx_neg <= start_dx_neg;
			dy_neg <= 1'b0; // everyone starts heading down
		end else if (frame_tick && run) begin
			// x axis, bounce costs the frame
			if (dx_neg ? (pos_x < step) : (pos_x > x_max - step))
				dx_neg <= !dx_neg;
			else
				pos_x <= dx_neg ? pos_x - step : pos_x + step;
			// y axis, same rule
			if (dy_neg ? (pos_y < step) : (pos_y > y_max - step))
				dy_neg <= !dy_neg;
			else
				pos_y <= dy_neg ? pos_y - step : pos_y + step;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || restart)
			alive <= 1'b1;
		else if (kill)
			alive <= 1'b0; // stays gone until restart
	end

	assign enemy = '{x: pos_x, y: pos_y, size: coord_t'(enemy_size), alive: alive};

endmodule

//--- rtl/hit_detect.sv
// ==========================================================
// player versus enemy collisions
// ==========================================================
`timescale 1ns/1ps

module hit_detect #(
	parameter int n_enemy = 3
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              frame_tick,
	input  logic [7:0]                        keycode,
	input  game_pkg::sprite_t                 player,
	input  game_pkg::sprite_t [n_enemy-1:0]   enemies,
	output logic [n_enemy-1:0]                kill,
	output logic                              player_hit
);
	import game_pkg::*;

	logic [n_enemy-1:0] overlap; // per enemy box overlap
	logic               attack;

	assign attack = (keycode == key_attack);

	// boxes must share at least one pixel, touching edges do not count
	always_comb begin
		overlap = '0;
		for (int i = 0; i < n_enemy; i++) begin
			overlap[i] = player.alive && enemies[i].alive
				&& ({1'b0, player.x} < {1'b0, enemies[i].x} + {1'b0, enemies[i].size})
				&& ({1'b0, enemies[i].x} < {1'b0, player.x} + {1'b0, player.size})
				&& ({1'b0, player.y} < {1'b0, enemies[i].y} + {1'b0, enemies[i].size})
				&& ({1'b0, enemies[i].y} < {1'b0, player.y} + {1'b0, player.size});
		end
	end

	// ==========================================================
	// one cycle strobes after the frame_tick
	// ==========================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			kill       <= '0;
			player_hit <= 1'b0;
		end else begin
			kill       <= (frame_tick && attack) ? overlap : '0;
			player_hit <= frame_tick && !attack && (|overlap); // caught unarmed
		end
	end

endmodule

//--- rtl/game_fsm.sv
// ==========================================================
// play / dead controller and score
// ==========================================================
`timescale 1ns/1ps

module game_fsm #(
	parameter int n_enemy = 3
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               frame_tick,
	input  logic [7:0]         keycode,
	input  logic               player_hit,
	input  logic [n_enemy-1:0] kill,
	output logic               run,
	output logic               restart,
	output logic               dead,
	output logic [3:0]         kills
);
	import game_pkg::*;

	typedef enum logic {st_play, st_dead} state_t;

	state_t     state;
	logic [7:0] kill_sum; // enemies killed this strobe
	logic [7:0] kill_next;

	always_comb begin
		kill_sum = '0;
		for (int i = 0; i < n_enemy; i++)
			kill_sum = kill_sum + 8'(kill[i]);
		kill_next = {4'b0, kills} + kill_sum;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= st_play;
			restart <= 1'b0;
			kills   <= '0;
		end else begin
			// enter while dead, only sampled on the frame boundary
			restart <= (state == st_dead) && frame_tick && (keycode == key_restart);
			if (restart) begin
				state <= st_play;
				kills <= '0;
			end else begin
				if (player_hit)
					state <= st_dead;
				kills <= (kill_next > 8'd15) ? 4'd15 : kill_next[3:0]; // saturate
			end
		end
	end

	assign run  = (state == st_play);
	assign dead = (state == st_dead);

endmodule

//--- rtl/pixel_mixer.sv
// ==========================================================
// pixel colouring and output stage
// ==========================================================
`timescale 1ns/1ps

module pixel_mixer #(
	parameter int n_enemy = 3
) (
	input  logic                            clk,
	input  logic                            rst,
	input  game_pkg::coord_t                draw_x,
	input  game_pkg::coord_t                draw_y,
	input  logic                            blank,
	input  logic                            hs_in,
	input  logic                            vs_in,
	input  game_pkg::sprite_t               player,
	input  game_pkg::sprite_t [n_enemy-1:0] enemies,
	output game_pkg::rgb_t                  rgb,
	output logic                            hs,
	output logic                            vs,
	output logic                            blank_out
);
	import game_pkg::*;

	rgb_t pix; // colour before the output register
	logic enemy_here;

	// pixel inside a live box
	function automatic logic in_box(coord_t px, coord_t py, sprite_t s);
		logic [10:0] x_end;
		logic [10:0] y_end;
		x_end = {1'b0, s.x} + {1'b0, s.size};
		y_end = {1'b0, s.y} + {1'b0, s.size};
		return s.alive && (px >= s.x) && ({1'b0, px} < x_end)
			&& (py >= s.y) && ({1'b0, py} < y_end);
	endfunction

	always_comb begin
		enemy_here = 1'b0;
		for (int i = 0; i < n_enemy; i++)
			enemy_here = enemy_here | in_box(draw_x, draw_y, enemies[i]);
		if (blank)                               pix = '0; // black in blanking
		else if (in_box(draw_x, draw_y, player)) pix = col_player; // player on top
		else if (enemy_here)                     pix = col_enemy;
		else                                     pix = col_bg;
	end

	// colour and syncs leave together, one cycle late
	always_ff @(posedge clk) begin
		if (rst) begin
			rgb       <= '0;
			hs        <= 1'b1;
			vs        <= 1'b1;
			blank_out <= 1'b1;
		end else begin
			rgb       <= pix;
			hs        <= hs_in;
			vs        <= vs_in;
			blank_out <= blank;
		end
	end

endmodule

//--- rtl/game_top.sv
// ==========================================================
// arena game top level
// ==========================================================
`timescale 1ns/1ps

module game_top #(
	parameter int h_active    = 640,
	parameter int h_total     = 800,
	parameter int v_active    = 480,
	parameter int v_total     = 525,
	parameter int h_sync      = 96,
	parameter int v_sync      = 2,
	parameter int n_enemy     = 3,
	parameter int player_size = 32,
	parameter int enemy_size  = 32,
	parameter int player_step = 4,
	parameter int enemy_step  = 2
) (
	input  logic              clk,
	input  logic              rst,
	input  logic [7:0]        keycode,
	output logic              hs,
	output logic              vs,
	output logic              blank,
	output game_pkg::rgb_t    rgb,
	output game_pkg::sprite_t player,
	output logic              dead,
	output logic [3:0]        kills
);
	import game_pkg::*;

	coord_t                 draw_x, draw_y;
	logic                   vt_blank, vt_hs, vt_vs; // raw raster, before the mixer stage
	logic                   frame_tick;
	logic                   run, restart, player_hit;
	logic [n_enemy-1:0]     kill;
	sprite_t [n_enemy-1:0]  enemies;

	video_timing #(.h_active(h_active), .h_total(h_total), .v_active(v_active),
		.v_total(v_total), .h_sync(h_sync), .v_sync(v_sync)) vt0 (
		.clk(clk), .rst(rst), .draw_x(draw_x), .draw_y(draw_y), .blank(vt_blank),
		.hs(vt_hs), .vs(vt_vs), .frame_tick(frame_tick));

	player_motion #(.h_active(h_active), .v_active(v_active),
		.player_size(player_size), .player_step(player_step)) pm0 (
		.clk(clk), .rst(rst), .frame_tick(frame_tick), .run(run), .restart(restart),
		.keycode(keycode), .player(player));

	// ==========================================================
	// enemy row, spaced along the top edge
	// ==========================================================
	for (genvar i = 0; i < n_enemy; i++) begin : g_enemy
		enemy_mover #(.h_active(h_active), .v_active(v_active),
			.start_x(2 + i * (enemy_size + 4)), .start_y(2),
			.start_dx_neg(i % 2 == 1), // odd ones head left
			.enemy_size(enemy_size), .enemy_step(enemy_step)) em (
			.clk(clk), .rst(rst), .frame_tick(frame_tick), .run(run),
			.restart(restart), .kill(kill[i]), .enemy(enemies[i]));
	end

	hit_detect #(.n_enemy(n_enemy)) hd0 (
		.clk(clk), .rst(rst), .frame_tick(frame_tick), .keycode(keycode),
		.player(player), .enemies(enemies), .kill(kill), .player_hit(player_hit));

	game_fsm #(.n_enemy(n_enemy)) fsm0 (
		.clk(clk), .rst(rst), .frame_tick(frame_tick), .keycode(keycode),
		.player_hit(player_hit), .kill(kill), .run(run), .restart(restart),
		.dead(dead), .kills(kills));

	pixel_mixer #(.n_enemy(n_enemy)) mix0 (
		.clk(clk), .rst(rst), .draw_x(draw_x), .draw_y(draw_y), .blank(vt_blank),
		.hs_in(vt_hs), .vs_in(vt_vs), .player(player), .enemies(enemies),
		.rgb(rgb), .hs(hs), .vs(vs), .blank_out(blank));

endmodule

//--- tests/game_sva.sv
// ==========================================================
// game top level assertions
// ==========================================================
`timescale 1ns/1ps

module game_sva #(
	parameter int h_active = 640,
	parameter int v_active = 480
) (
	input logic              clk,
	input logic              rst,
	input logic              frame_tick,
	input logic              blank,
	input logic              restart,
	input game_pkg::rgb_t    rgb,
	input logic [3:0]        kills,
	input game_pkg::sprite_t player
);

	a_tick_one: assert property (@(posedge clk) disable iff (rst)
		frame_tick |=> !frame_tick) else $error("frame_tick held past one cycle");

	// blank here is the registered one, aligned with rgb
	a_blank_black: assert property (@(posedge clk) disable iff (rst)
		blank |-> (rgb == '0)) else $error("colour during blank");

	a_kills_up: assert property (@(posedge clk) disable iff (rst)
		!restart |=> (kills >= $past(kills))) else $error("kills went down");

	a_in_field: assert property (@(posedge clk) disable iff (rst)
		(({1'b0, player.x} + {1'b0, player.size}) <= 11'(h_active))
		&& (({1'b0, player.y} + {1'b0, player.size}) <= 11'(v_active)))
		else $error("player left the field");

endmodule

bind game_top game_sva #(.h_active(h_active), .v_active(v_active)) sva0 (
	.clk(clk), .rst(rst), .frame_tick(frame_tick), .blank(blank),
	.restart(restart), .rgb(rgb), .kills(kills), .player(player));

//--- tests/tb_game.sv
// ==========================================================
// arena game testbench
// ==========================================================
`timescale 1ns/1ps

module tb_game;
	import game_pkg::*;

	// small raster so a frame is only 1200 clocks
	localparam int h_active  = 32;
	localparam int h_total   = 40;
	localparam int v_active  = 24;
	localparam int v_total   = 30;
	localparam int h_sync    = 4;
	localparam int v_sync    = 2;
	localparam int n_rec_max = 16;

	logic       clk;
	logic       rst;
	logic [7:0] keycode;
	logic       hs;
	logic       vs;
	logic       blank;
	rgb_t       rgb;
	sprite_t    player;
	logic       dead;
	logic [3:0] kills;

	logic [47:0] recs [0:n_rec_max-1]; // key, frames, x, y, dead, kills

	int   errors = 0;
	int   tests = 0;
	int   frames_checked = 0;
	int   pixel_checks = 0;
	int   limit_ns = 0; // watchdog budget in ns, set once the data is read
	int   hs_pulses = 0;
	int   vs_low = 0;
	int   active = 0;
	logic frame_seen = 1'b0; // first vs edge after reset opens the count
	logic hs_prev = 1'b1;
	logic vs_prev = 1'b1;
	logic pix_pending = 1'b0; // player corner seen on the raster last cycle

	game_top #(.h_active(h_active), .h_total(h_total), .v_active(v_active),
		.v_total(v_total), .h_sync(h_sync), .v_sync(v_sync), .n_enemy(3),
		.player_size(4), .enemy_size(4), .player_step(2), .enemy_step(1)) dut0 (
		.clk(clk), .rst(rst), .keycode(keycode), .hs(hs), .vs(vs), .blank(blank),
		.rgb(rgb), .player(player), .dead(dead), .kills(kills));

	always #50 clk = ~clk; // 100 ns period

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t ns: %s got %0h expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	// count frame strobes sampled mid cycle
	task automatic wait_frames(input int n);
		int seen;
		seen = 0;
		while (seen < n) begin
			@(negedge clk);
			if (dut0.frame_tick)
				seen++;
		end
	endtask

	// ==========================================================
	// raster and pixel monitor
	// ==========================================================
	always @(negedge clk) begin
		if (!rst) begin
			if (pix_pending) begin
				check_eq(32'(rgb), 32'(col_player), "colour at player corner");
				pixel_checks++;
			end
			pix_pending = !dut0.vt_blank && player.alive
				&& (dut0.draw_x == player.x) && (dut0.draw_y == player.y);
			if (blank)
				check_eq(32'(rgb), 32'd0, "rgb during blank");
			if (hs_prev && !hs)
				hs_pulses++; // one per line
			if (!vs)
				vs_low++;
			if (!blank)
				active++;
			if (!vs_prev && vs) begin // vsync just ended so one whole frame has passed
				if (frame_seen) begin
					check_eq(32'(hs_pulses), 32'(v_total), "hsync pulses per frame");
					check_eq(32'(vs_low), 32'(v_sync * h_total), "vsync low clocks");
					check_eq(32'(active), 32'(h_active * v_active), "active pixels");
					frames_checked++;
				end
				frame_seen = 1'b1;
				hs_pulses = 0;
				vs_low = 0;
				active = 0;
			end
			hs_prev = hs;
			vs_prev = vs;
		end
	end

	// ==========================================================
	// watchdog
	// ==========================================================
	initial begin
		wait (limit_ns != 0);
		#(limit_ns);
		$display("simulation timed out after %0d ns, the DUT stopped producing frames",
			limit_ns);
		$display("sim failed");
		$finish;
	end

	// ==========================================================
	// data driven test sequence
	// ==========================================================
	initial begin
		int         i;
		int         frames_total;
		logic [47:0] r;
		clk = 1'b0;
		rst = 1'b1;
		keycode = 8'h00;
		frames_total = 0;
		for (int k = 0; k < n_rec_max; k++)
			recs[k] = '0;
		$readmemh("tests/game_testdata.txt", recs);
		for (int k = 0; k < n_rec_max; k++)
			frames_total += int'(recs[k][39:32]); // empty slots add zero
		limit_ns = (frames_total + 4) * h_total * v_total * 100 + 20 * 100;

		repeat (10) @(posedge clk);
		#1 rst = 1'b0;

		i = 0;
		while (i < n_rec_max && recs[i][39:32] != 8'd0) begin
			r = recs[i];
			@(posedge clk);
			#1 keycode = r[47:40];
			wait_frames(int'(r[39:32]));
			repeat (4) @(negedge clk); // strobes and restart settle
			check_eq(32'(player.x), 32'(r[31:20]), "player x");
			check_eq(32'(player.y), 32'(r[19:8]), "player y");
			check_eq(32'(dead), 32'(r[7:4]), "dead");
			check_eq(32'(kills), 32'(r[3:0]), "kills");
			check_eq(32'(player.alive), 32'(r[7:4] == 4'h0), "player alive"); // drawn only in play
			tests++;
			$display("test %0d done: key %h for %0d frames, player (%0d,%0d) dead %0b kills %0d",
				i, r[47:40], r[39:32], player.x, player.y, dead, kills);
			i++;
		end

		if (tests == 0) begin
			$display("no test records were read from the data file");
			errors++;
		end
		if (frames_checked == 0 || pixel_checks == 0) begin
			$display("the raster monitor never completed a frame or a pixel check");
			errors++;
		end
		$display("tests %0d, frames checked %0d, pixel checks %0d, errors %0d",
			tests, frames_checked, pixel_checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

//--- tests/game_testdata.txt
// one record per line: key(2) frames(2) x(3) y(3) dead(1) kills(1), all hex
// x y dead kills are expected after the last frame of the record
2c0c00e00a01
001200e00a11
070300e00a11
280100e00a00
1a0a00e00000
040a00000000
160f00001400
071401c01400

//--- flist.f
rtl/game_pkg.sv
rtl/video_timing.sv
rtl/player_motion.sv
rtl/enemy_mover.sv
rtl/hit_detect.sv
rtl/game_fsm.sv
rtl/pixel_mixer.sv
rtl/game_top.sv
tests/game_sva.sv
tests/tb_game.sv

//--- run_sim.sh
#!/bin/bash
# build and run the arena game testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module tb_game -o vtb_game \
	&& ./obj_dir/vtb_game | tee /dev/stderr | grep -x "sim passed" > /dev/null \
	&& echo "run_sim: PASS" \
	|| { echo "run_sim: FAIL"; exit 1; }
